// File: src/memPkg.sv
/* Shared types and constants of the KS-10 memory controller.
   Words are numbered 0..35 with bit 0 as MSB, as on the backplane. */

`default_nettype none

package memPkg;

   //////////////////////////////////////////////////////////////////////
   // Bus word and address word layout
   //////////////////////////////////////////////////////////////////////

   typedef logic [0:35] word36_t;               // Backplane data/address word

   // Flag positions in the upper bits of the address word
   localparam int BUS_READ_BIT   = 3;
   localparam int BUS_WRTEST_BIT = 4;
   localparam int BUS_WRITE_BIT  = 5;
   localparam int BUS_PHYS_BIT   = 8;
   localparam int BUS_IO_BIT     = 10;

   // Device number field
   function automatic logic [0:3] busDev(input word36_t addr);
      return addr[14:17];
   endfunction

   // I/O register address field
   function automatic logic [18:35] busIoAddr(input word36_t addr);
      return addr[18:35];
   endfunction

   // Memory address field
   function automatic logic [16:35] busMemAddr(input word36_t addr);
      return addr[16:35];
   endfunction

   //////////////////////////////////////////////////////////////////////
   // Address map
   //////////////////////////////////////////////////////////////////////

   localparam logic [0:3]   MEM_DEVICE = 4'd0;          // Memory controller is device 0
   localparam logic [18:35] MSR_IOADDR = 18'o100000;    // Status register I/O address
   localparam logic [16:35] HSB_BASE   = 20'o0376000;   // Half-speed block, bits 16-30 match

   // Writable MSR bits
   // Error flags in bits 0-5, control field in bits 32-35
   localparam word36_t MSR_WRITE_MASK = 36'o770000_000017;

   //////////////////////////////////////////////////////////////////////
   // Decoded command
   //////////////////////////////////////////////////////////////////////

   typedef enum logic [2:0] {
      OP_NONE,          // Not for us, never acknowledged
      OP_MSR_RD,
      OP_MSR_WR,
      OP_MEM_RD,
      OP_MEM_WR,
      OP_MEM_WRTEST     // Read the word, store nothing
   } memOp_t;

   typedef enum logic [1:0] {
      TGT_MAIN,
      TGT_HSB,
      TGT_MSR,
      TGT_NONE          // Nonexistent memory
   } memTarget_t;

   typedef struct packed {
      memOp_t      op;
      memTarget_t  target;
      logic [14:0] index;  // Word index inside the target array
   } memCmd_t;

endpackage

`default_nettype wire

// File: src/memArrayIf.sv
/* Connection from the access controller to one word array.
   rdData is registered in the array, valid the cycle after en. */

`timescale 1ns/1ps
`default_nettype none

interface memArrayIf #(
   parameter int ADDR_WIDTH = 15   // Word index width of the array
) ();

   import memPkg::*;

   logic                  en;      // Access strobe, one cycle
   logic                  wr;      // Store wrData when enabled
   logic [ADDR_WIDTH-1:0] addr;    // Word index
   word36_t               wrData;  // Write word
   word36_t               rdData;  // Registered read word

   // Access controller side
   modport ctrl (output en, wr, addr, wrData, input rdData);

   // Array side
   modport array (input en, wr, addr, wrData, output rdData);

endinterface

`default_nettype wire

// File: src/memAddrDecode.sv
/* Combinational decode of the bus address word.
   All address range tests of the controller live here. */

`timescale 1ns/1ps
`default_nettype none

module memAddrDecode (
   input  memPkg::word36_t busAddr,   // Flags, device and address
   output memPkg::memCmd_t cmd        // Decoded operation and target
);

   import memPkg::*;

   // Flags
   logic busRead;
   logic busWrtest;
   logic busWrite;
   logic busPhys;
   logic busIo;

   // Range hits
   logic msrHit;
   logic mainHit;
   logic hsbHit;

   logic [16:35] memAddr;

   assign busRead   = busAddr[BUS_READ_BIT];
   assign busWrtest = busAddr[BUS_WRTEST_BIT];
   assign busWrite  = busAddr[BUS_WRITE_BIT];
   assign busPhys   = busAddr[BUS_PHYS_BIT];
   assign busIo     = busAddr[BUS_IO_BIT];
   assign memAddr   = busMemAddr(busAddr);

   // MSR needs physical I/O to device 0 at the MSR address
   assign msrHit  = busIo & busPhys & (busDev(busAddr) == MEM_DEVICE)
                  & (busIoAddr(busAddr) == MSR_IOADDR);
   assign mainHit = (memAddr[16:20] == 5'd0);              // First 32K words
   assign hsbHit  = (memAddr[16:30] == HSB_BASE[16:30]);   // 32-word block

   always_comb
   begin
      cmd = '{op: OP_NONE, target: TGT_NONE, index: '0};
      if (busIo)
      begin
         if (msrHit & busRead)
            cmd = '{op: OP_MSR_RD, target: TGT_MSR, index: '0};
         else if (msrHit & busWrite)
            cmd = '{op: OP_MSR_WR, target: TGT_MSR, index: '0};
      end
      else
      begin
         // Target first, op below
         if (mainHit)
            cmd = '{op: OP_NONE, target: TGT_MAIN, index: memAddr[21:35]};
         else if (hsbHit)
            cmd = '{op: OP_NONE, target: TGT_HSB, index: {10'd0, memAddr[31:35]}};

         // Read of nonexistent memory stays OP_NONE and times out
         if (busRead & (mainHit | hsbHit))
            cmd.op = OP_MEM_RD;
         else if (busWrtest & (mainHit | hsbHit))
            cmd.op = OP_MEM_WRTEST;
         else if (busWrite)
            cmd.op = OP_MEM_WR;     // Nonexistent memory still acked
      end
   end

endmodule

`default_nettype wire

// File: src/memWaitTimer.sv
/* Wait-state down-counter. done rises WAIT_CYCLES cycles after load.
   Three-bit count, so WAIT_CYCLES is limited to 7. */

`timescale 1ns/1ps
`default_nettype none

module memWaitTimer #(
   parameter int WAIT_CYCLES = 2   // Reload value
) (
   input  logic memCLK,
   input  logic rst,
   input  logic load,    // Restart the count
   output logic done     // Count ran out
);

   logic [2:0] count;

   always_ff @(posedge memCLK)
   begin
      if (rst)
         count <= 3'd0;
      else if (load)
         count <= 3'(WAIT_CYCLES);
      else if (count != 3'd0)
         count <= count - 3'd1;   // Stops at zero
   end

   assign done = (count == 3'd0);   // High until next load

endmodule

`default_nettype wire

// File: src/memWordArray.sv
/* Single-port array of 36-bit words with registered read.
   No reset; contents are undefined until written. */

`timescale 1ns/1ps
`default_nettype none

module memWordArray #(
   parameter int ADDR_WIDTH = 15   // 2**ADDR_WIDTH words
) (
   input  logic     memCLK,
   memArrayIf.array port
);

   import memPkg::*;

   localparam int DEPTH = 2 ** ADDR_WIDTH;

   word36_t mem [0:DEPTH-1];

   always_ff @(posedge memCLK)
   begin
      if (port.en)
      begin
         if (port.wr)
            mem[port.addr] <= port.wrData;
         port.rdData <= mem[port.addr];   // Old word on a write, read-before-write
      end
   end

endmodule

`default_nettype wire

// File: src/memStatusReg.sv
/* Memory status register. Bits outside MSR_WRITE_MASK read as zero. */

`timescale 1ns/1ps
`default_nettype none

module memStatusReg (
   input  logic            memCLK,
   input  logic            rst,
   input  logic            write,   // Store data this cycle
   input  memPkg::word36_t data,
   output memPkg::word36_t value    // Current register contents
);

   import memPkg::*;

   always_ff @(posedge memCLK)
   begin
      if (rst)
         value <= '0;
      else if (write)
         value <= data & MSR_WRITE_MASK;   // Visible next cycle
   end

endmodule

`default_nettype wire

// File: src/memAccessCtrl.sv
/* Access sequencer: IDLE, WAIT, ACK. Command is latched at the start.
   Requester must hold busReq and busAddr until busAck is sampled. */

`timescale 1ns/1ps
`default_nettype none

module memAccessCtrl #(
   parameter int WAIT_CYCLES = 2   // Wait states, 1 to 7
) (
   input  logic            memCLK,
   input  logic            rst,
   input  logic            busReq,
   input  memPkg::memCmd_t cmd,         // From the decoder
   input  memPkg::word36_t busDataIn,
   output logic            busAck,
   output memPkg::word36_t busDataOut,  // Held until the next ack
   memArrayIf.ctrl         mainIf,
   memArrayIf.ctrl         hsbIf,
   output logic            timerLoad,
   input  logic            timerDone,
   output logic            msrWrite,
   input  memPkg::word36_t msrValue
);

   import memPkg::*;

   typedef enum logic [1:0] {IDLE, WAIT, ACK} ctrlState_t;

   ctrlState_t state;
   memCmd_t    curCmd;     // Command of the access in progress
   logic       start;
   word36_t    readWord;   // Word for busDataOut at ACK entry

   assign start     = (state == IDLE) & busReq & (cmd.op != OP_NONE);
   assign timerLoad = start;
   assign msrWrite  = start & (cmd.op == OP_MSR_WR);   // Stored on the start edge
   assign busAck    = (state == ACK);

   ///////////////////////////////////////////////////////////////////////
   // Read word select
   ///////////////////////////////////////////////////////////////////////

   always_comb
   begin
      case (curCmd.op)
         OP_MSR_RD, OP_MSR_WR:
            readWord = msrValue;
         OP_MEM_RD, OP_MEM_WRTEST:
            readWord = (curCmd.target == TGT_HSB) ? hsbIf.rdData : mainIf.rdData;
         default:
            readWord = busDataOut;   // Writes keep the old word
      endcase
   end

   ///////////////////////////////////////////////////////////////////////
   // State machine
   ///////////////////////////////////////////////////////////////////////

   always_ff @(posedge memCLK)
   begin
      if (rst)
      begin
         state      <= IDLE;
         curCmd     <= '{op: OP_NONE, target: TGT_NONE, index: '0};
         mainIf.en  <= 1'b0;
         hsbIf.en   <= 1'b0;
         busDataOut <= '0;
      end
      else
      begin
         mainIf.en <= 1'b0;   // One-cycle strobes
         hsbIf.en  <= 1'b0;
         case (state)
            IDLE:
               if (start)
               begin
                  curCmd    <= cmd;
                  mainIf.en <= (cmd.target == TGT_MAIN);
                  hsbIf.en  <= (cmd.target == TGT_HSB);
                  state     <= WAIT;
               end
            WAIT:
               if (timerDone)   // Array word ready by now
               begin
                  busDataOut <= readWord;
                  state      <= ACK;
               end
            default:
               state <= IDLE;   // ACK lasts one cycle
         endcase
      end
   end

   // Array address and data, taken with the request
   always_ff @(posedge memCLK)
   begin
      if (start)
      begin
         mainIf.addr   <= cmd.index;
         hsbIf.addr    <= cmd.index[4:0];
         mainIf.wr     <= (cmd.op == OP_MEM_WR);   // Write-test stores nothing
         hsbIf.wr      <= (cmd.op == OP_MEM_WR);
         mainIf.wrData <= busDataIn;
         hsbIf.wrData  <= busDataIn;
      end
   end

endmodule

`default_nettype wire

// File: src/ks10Mem.sv
/* KS-10 memory controller top: 32K-word core, 32-word HSB and the MSR.
   Request/acknowledge handshake on memCLK; no acknowledge means bus timeout. */

`timescale 1ns/1ps
`default_nettype none

module ks10Mem #(
   parameter int WAIT_CYCLES = 2   // Array wait states, 1 to 7
) (
   input  logic            memCLK,
   input  logic            rst,
   input  logic            busReq,      // Held until busAck
   input  memPkg::word36_t busAddr,
   input  memPkg::word36_t busDataIn,
   output logic            busAck,
   output memPkg::word36_t busDataOut
);

   import memPkg::*;

   memCmd_t cmd;
   logic    timerLoad;
   logic    timerDone;
   logic    msrWrite;
   word36_t msrValue;

   memArrayIf #(.ADDR_WIDTH(15)) mainIf ();   // Main core
   memArrayIf #(.ADDR_WIDTH(5))  hsbIf ();    // Half-speed block

   memAddrDecode decode (
      .busAddr (busAddr),
      .cmd     (cmd)
   );

   memAccessCtrl #(.WAIT_CYCLES(WAIT_CYCLES)) ctrl (
      .memCLK     (memCLK),
      .rst        (rst),
      .busReq     (busReq),
      .cmd        (cmd),
      .busDataIn  (busDataIn),
      .busAck     (busAck),
      .busDataOut (busDataOut),
      .mainIf     (mainIf.ctrl),
      .hsbIf      (hsbIf.ctrl),
      .timerLoad  (timerLoad),
      .timerDone  (timerDone),
      .msrWrite   (msrWrite),
      .msrValue   (msrValue)
   );

   memWaitTimer #(.WAIT_CYCLES(WAIT_CYCLES)) waitTimer (
      .memCLK (memCLK),
      .rst    (rst),
      .load   (timerLoad),
      .done   (timerDone)
   );

   memWordArray #(.ADDR_WIDTH(15)) mainArray (
      .memCLK (memCLK),
      .port   (mainIf.array)
   );

   memWordArray #(.ADDR_WIDTH(5)) hsbArray (
      .memCLK (memCLK),
      .port   (hsbIf.array)
   );

   // MSR takes write data straight from the bus
   memStatusReg statusReg (
      .memCLK (memCLK),
      .rst    (rst),
      .write  (msrWrite),
      .data   (busDataIn),
      .value  (msrValue)
   );

endmodule

`default_nettype wire

// File: sim/ks10MemVectors.svh
/* Directed bus operations for ks10MemTb, applied in order from row 0.
   Later rows read back words stored by earlier rows. Expects WAIT_CYCLES 2. */

`ifndef KS10_MEM_VECTORS_SVH
`define KS10_MEM_VECTORS_SVH

localparam int NUM_VECTORS = 32;

// Columns: op, address word, write data, expected ack, expected read word
// Expected word is ignored on writes and on rows without ack
vecRow_t vectors [0:NUM_VECTORS-1] = '{
   // MSR reads zero after reset, writes are masked
   '{ROW_RD, FLAG_RD | MSR_REG,             36'o0,             1'b1, 36'o0},
   '{ROW_WR, FLAG_WR | MSR_REG,             36'o777777_777777, 1'b1, 36'o0},
   '{ROW_RD, FLAG_RD | MSR_REG,             36'o0,             1'b1, 36'o770000_000017},
   '{ROW_WR, FLAG_WR | MSR_REG,             36'o123456_701234, 1'b1, 36'o0},
   '{ROW_RD, FLAG_RD | MSR_REG,             36'o0,             1'b1, 36'o120000_000014},
   // Main core, first and last word
   '{ROW_WR, FLAG_WR | 36'o000000,          36'o707070_707070, 1'b1, 36'o0},
   '{ROW_WR, FLAG_WR | 36'o077777,          36'o123456_765432, 1'b1, 36'o0},
   '{ROW_RD, FLAG_RD | 36'o000000,          36'o0,             1'b1, 36'o707070_707070},
   '{ROW_RD, FLAG_RD | 36'o077777,          36'o0,             1'b1, 36'o123456_765432},
   // HSB word 3 kept apart from main word 3
   '{ROW_WR, FLAG_WR | 36'o000003,          36'o333333_000003, 1'b1, 36'o0},
   '{ROW_WR, FLAG_WR | HSB_ADDR | 36'd3,    36'o444444_000003, 1'b1, 36'o0},
   '{ROW_WR, FLAG_WR | HSB_ADDR | 36'd31,   36'o555555_000037, 1'b1, 36'o0},
   '{ROW_RD, FLAG_RD | 36'o000003,          36'o0,             1'b1, 36'o333333_000003},
   '{ROW_RD, FLAG_RD | HSB_ADDR | 36'd3,    36'o0,             1'b1, 36'o444444_000003},
   '{ROW_RD, FLAG_RD | HSB_ADDR | 36'd31,   36'o0,             1'b1, 36'o555555_000037},
   // Write-test returns the old word and stores nothing
   '{ROW_RD, FLAG_WT | 36'o000003,          36'o666666_666666, 1'b1, 36'o333333_000003},
   '{ROW_RD, FLAG_RD | 36'o000003,          36'o0,             1'b1, 36'o333333_000003},
   '{ROW_RD, FLAG_WT | HSB_ADDR | 36'd3,    36'o666666_666666, 1'b1, 36'o444444_000003},
   '{ROW_RD, FLAG_RD | HSB_ADDR | 36'd3,    36'o0,             1'b1, 36'o444444_000003},
   // No ack: nonexistent memory, bad MSR access
   '{ROW_RD, FLAG_RD | 36'o100000,          36'o0,             1'b0, 36'o0},
   '{ROW_RD, FLAG_RD | 36'o377777,          36'o0,             1'b0, 36'o0},
   '{ROW_RD, FLAG_WT | 36'o200000,          36'o0,             1'b0, 36'o0},
   '{ROW_RD, FLAG_RD | MSR_REG | DEV_ONE,   36'o0,             1'b0, 36'o0},
   '{ROW_RD, FLAG_RD | MSR_REG | 36'd1,     36'o0,             1'b0, 36'o0},   // Wrong I/O addr
   '{ROW_RD, FLAG_RD | FLAG_IO | 36'o100000, 36'o0,            1'b0, 36'o0},   // Not physical
   '{ROW_WR, FLAG_WR | FLAG_IO | 36'o100000, 36'o777777_777777, 1'b0, 36'o0},
   '{ROW_RD, FLAG_RD | MSR_REG,             36'o0,             1'b1, 36'o120000_000014},
   // Nonexistent writes acked, aliases of main 3 and HSB 3 untouched
   '{ROW_WR, FLAG_WR | 36'o100003,          36'o777777_777777, 1'b1, 36'o0},
   '{ROW_WR, FLAG_WR | HSB_ADDR | 36'o43,   36'o777777_777777, 1'b1, 36'o0},
   '{ROW_RD, FLAG_RD | 36'o000003,          36'o0,             1'b1, 36'o333333_000003},
   '{ROW_RD, FLAG_RD | HSB_ADDR | 36'd3,    36'o0,             1'b1, 36'o444444_000003},
   '{ROW_RD, FLAG_RD | 36'o000000,          36'o0,             1'b1, 36'o707070_707070}
};

`endif

// File: sim/ks10MemTb.sv
/* Testbench for ks10Mem with WAIT_CYCLES 2: directed table, then random
   write/read-back of main memory against a shadow copy. */

`timescale 1ns/1ps
`default_nettype none

module ks10MemTb;

   import memPkg::*;

   localparam int WAIT_CYCLES = 2;
   localparam int DRIVE_DELAY = 1;                     // ns after rising edge
   localparam int RAND_COUNT  = 64;
   localparam logic [31:0] LFSR_SEED = 32'h7b64_73e1;
   localparam logic [31:0] LFSR_TAPS = 32'hA300_0000;  // Right-shift Galois form

   // Address word flags, bit 0 is the MSB
   localparam word36_t FLAG_RD   = 36'o040000_000000;  // Bit 3
   localparam word36_t FLAG_WT   = 36'o020000_000000;  // Bit 4
   localparam word36_t FLAG_WR   = 36'o010000_000000;  // Bit 5
   localparam word36_t FLAG_PHYS = 36'o001000_000000;  // Bit 8
   localparam word36_t FLAG_IO   = 36'o000200_000000;  // Bit 10
   localparam word36_t DEV_ONE   = 36'o000001_000000;  // Device field = 1
   localparam word36_t MSR_REG   = FLAG_IO | FLAG_PHYS | 36'o100000;
   localparam word36_t HSB_ADDR  = 36'o376000;

   typedef enum logic {ROW_WR, ROW_RD} rowOp_t;

   typedef struct packed {
      rowOp_t  op;
      word36_t addr;
      word36_t data;
      logic    expAck;
      word36_t expWord;
   } vecRow_t;

   `include "ks10MemVectors.svh"

   // Every request fits in WAIT_CYCLES+6 cycles, doubled for margin
   localparam int WATCHDOG_NS = (NUM_VECTORS + 2 * RAND_COUNT) * (WAIT_CYCLES + 6) * 4 * 2;

   logic    memCLK;
   logic    rst;
   logic    busReq;
   word36_t busAddr;
   word36_t busDataIn;
   logic    busAck;
   word36_t busDataOut;

   logic [31:0] lfsrState = LFSR_SEED;
   logic [14:0] randAddr [0:RAND_COUNT-1];   // Write order of random phase
   word36_t     shadow [0:32767];            // Expected main memory words

   int checkCount    = 0;
   int wordErrors    = 0;
   int ackErrors     = 0;
   int latencyErrors = 0;

   ks10Mem #(.WAIT_CYCLES(WAIT_CYCLES)) dut (
      .memCLK     (memCLK),
      .rst        (rst),
      .busReq     (busReq),
      .busAddr    (busAddr),
      .busDataIn  (busDataIn),
      .busAck     (busAck),
      .busDataOut (busDataOut)
   );

   initial
   begin
      memCLK = 1'b0;
      forever #2 memCLK = ~memCLK;   // 4 ns period
   end

   //////////////////////////////////////////////////////////////////////
   // Random source
   //////////////////////////////////////////////////////////////////////

   function automatic logic lfsrBit();
      logic outBit;
      outBit    = lfsrState[0];
      lfsrState = lfsrState >> 1;
      if (outBit)
         lfsrState = lfsrState ^ LFSR_TAPS;
      return outBit;
   endfunction

   // One LFSR step per bit, right-aligned
   function automatic word36_t randomBits(input int count);
      word36_t value;
      value = '0;
      for (int i = 0; i < count; i++)
         value = {value[1:35], lfsrBit()};
      return value;
   endfunction

   //////////////////////////////////////////////////////////////////////
   // Compare tasks
   //////////////////////////////////////////////////////////////////////

   task automatic checkWord(input string what, input word36_t expected, input word36_t seen);
      checkCount++;
      if (seen !== expected)
      begin
         wordErrors++;
         $display("MISMATCH at %0t: %s read word %012o, expected %012o",
                  $time, what, seen, expected);
      end
   endtask

   task automatic checkAck(input string what, input logic expected, input logic seen);
      checkCount++;
      if (seen !== expected)
      begin
         ackErrors++;
         $display("MISMATCH at %0t: %s acknowledge %0b, expected %0b",
                  $time, what, seen, expected);
      end
   endtask

   task automatic checkLatency(input string what, input int cycles);
      checkCount++;
      if (cycles != WAIT_CYCLES + 1)
      begin
         latencyErrors++;
         $display("MISMATCH at %0t: %s acknowledge after %0d cycles, expected %0d",
                  $time, what, cycles, WAIT_CYCLES + 1);
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // Bus operations, entered DRIVE_DELAY after a rising edge
   //////////////////////////////////////////////////////////////////////

   task automatic busRequest(input word36_t addr, input word36_t data, output logic acked,
                             output int cycles, output word36_t rdWord);
      acked     = 1'b0;
      cycles    = 0;
      rdWord    = '0;
      busAddr   = addr;
      busDataIn = data;
      busReq    = 1'b1;
      // Cycle 0 begins at the edge that first samples busReq
      while (!acked && cycles < WAIT_CYCLES + 4)
      begin
         @(posedge memCLK);
         #DRIVE_DELAY;
         if (busAck)
         begin
            acked  = 1'b1;
            rdWord = busDataOut;   // Valid while busAck is high
         end
         else
            cycles++;
      end
      if (acked)
      begin
         @(posedge memCLK);   // Ack sampled here
         #DRIVE_DELAY;
      end
      busReq = 1'b0;
   endtask

   task automatic busWrite(input string what, input word36_t addr, input word36_t data,
                           input logic expAck);
      logic    acked;
      int      cycles;
      word36_t rdWord;
      busRequest(addr, data, acked, cycles, rdWord);
      checkAck(what, expAck, acked);
      if (acked && expAck)
         checkLatency(what, cycles);
   endtask

   task automatic busRead(input string what, input word36_t addr, input word36_t data,
                          input logic expAck, input word36_t expWord);
      logic    acked;
      int      cycles;
      word36_t rdWord;
      busRequest(addr, data, acked, cycles, rdWord);
      checkAck(what, expAck, acked);
      if (acked && expAck)
      begin
         checkLatency(what, cycles);
         checkWord(what, expWord, rdWord);
      end
   endtask

   initial
   begin : stimulus
      vecRow_t     row;
      word36_t     rnd;
      logic [14:0] idx;
      int          k;

      rst       = 1'b1;
      busReq    = 1'b0;
      busAddr   = '0;
      busDataIn = '0;
      repeat (4) @(posedge memCLK);
      #DRIVE_DELAY;
      rst = 1'b0;

      // Directed rows
      for (int i = 0; i < NUM_VECTORS; i++)
      begin
         row = vectors[i];
         if (row.op == ROW_WR)
            busWrite($sformatf("row %0d", i), row.addr, row.data, row.expAck);
         else
            busRead($sformatf("row %0d", i), row.addr, row.data, row.expAck, row.expWord);
      end

      // Random writes, main memory only
      for (int i = 0; i < RAND_COUNT; i++)
      begin
         rnd         = randomBits(15);
         idx         = rnd[21:35];
         randAddr[i] = idx;
         shadow[idx] = randomBits(36);   // Last write wins on repeats
         busWrite($sformatf("random write %0d", i), FLAG_WR | word36_t'(idx),
                  shadow[idx], 1'b1);
      end

      // Read back in permuted order, 37 is odd so every index appears once
      for (int i = 0; i < RAND_COUNT; i++)
      begin
         k   = (i * 37 + 11) % RAND_COUNT;
         idx = randAddr[k];
         busRead($sformatf("random read %0d", k), FLAG_RD | word36_t'(idx), '0,
                 1'b1, shadow[idx]);
      end

      repeat (2) @(posedge memCLK);
      $display("Checks %0d, word errors %0d, ack errors %0d, latency errors %0d",
               checkCount, wordErrors, ackErrors, latencyErrors);
      if (wordErrors + ackErrors + latencyErrors == 0)
         $display("Testbench passed");
      else
         $display("Testbench failed");
      $finish;
   end

   initial
   begin : watchdog
      #(WATCHDOG_NS);
      $display("Run did not finish within %0d ns, a request hung", WATCHDOG_NS);
      $display("Testbench failed");
      $finish;
   end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+sim
src/memPkg.sv
src/memArrayIf.sv
src/memAddrDecode.sv
src/memWaitTimer.sv
src/memWordArray.sv
src/memStatusReg.sv
src/memAccessCtrl.sv
src/ks10Mem.sv
sim/ks10MemTb.sv

// File: Bender.yml
package:
  name: ks10_mem

sources:
  # RTL, package first
  - src/memPkg.sv
  - src/memArrayIf.sv
  - src/memAddrDecode.sv
  - src/memWaitTimer.sv
  - src/memWordArray.sv
  - src/memStatusReg.sv
  - src/memAccessCtrl.sv
  - src/ks10Mem.sv
  # Testbench, vector table included from sim
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/ks10MemTb.sv
